//--- hdl/log_pkg.sv
// Shared widths, PRBS seed, bus structs, status word and the log read word union
`default_nettype none

package log_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and constants
   ////////////////////////////////////////////////////////////
   localparam int NB_DATA_LOG = 8;              // Sample width
   localparam int NB_ADDR_LOG = 5;              // 32 log entries
   localparam int NB_WB_ADDR  = 6;              // Top bit selects status
   localparam int NB_COUNT    = 6;              // Holds up to 2**NB_ADDR_LOG
   localparam int NB_PRBS     = 9;

   localparam logic [NB_PRBS-1:0] PRBS_SEED = '1;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                   valid;
      logic [NB_DATA_LOG-1:0] data;
   } sample_t;

   // Master side of a classic cycle
   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [NB_WB_ADDR-1:0]  addr;
      logic [NB_DATA_LOG-1:0] data;
   } wb_req_t;

   typedef struct packed {
      logic                   ack;
      logic [NB_DATA_LOG-1:0] data;
   } wb_rsp_t;

   typedef struct packed {
      logic                full;
      logic                run;
      logic [NB_COUNT-1:0] count;   // Samples stored so far
   } log_status_t;

   // Read word is a sample or the status, by address top bit
   typedef union packed {
      logic [NB_DATA_LOG-1:0] sample;
      log_status_t            status;
   } log_word_u;

endpackage

`default_nettype wire

//--- hdl/prbs_symbol_source.sv
// PRBS9 symbol source with a periodic sample strobe
`default_nettype none
`timescale 1ns/100ps

module prbs_symbol_source #(
   parameter int SAMPLE_PERIOD = 3   // Clocks per sample
) (
   input  wire logic         i_clock,
   input  wire logic         i_counter_rst,
   output log_pkg::sample_t  o_sample
);

   localparam int NB_PERIOD = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;

   logic [NB_PERIOD-1:0]        period_cnt;
   logic                        strobe;
   logic [log_pkg::NB_PRBS-1:0] lfsr;
   logic                        valid;

   assign strobe = (period_cnt == NB_PERIOD'(SAMPLE_PERIOD - 1));

   ////////////////////////////////////////////////////////////
   // Sample period counter
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      if (i_counter_rst) begin
         period_cnt <= '0;
      end else if (strobe) begin
         period_cnt <= '0;
      end else begin
         period_cnt <= period_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // LFSR, taps 9 and 5, shifting left
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      if (i_counter_rst) begin
         lfsr  <= log_pkg::PRBS_SEED;
         valid <= 1'b0;
      end else begin
         valid <= strobe;   // Lines up with the advanced register
         if (strobe) begin
            lfsr <= {lfsr[log_pkg::NB_PRBS-2:0], lfsr[log_pkg::NB_PRBS-1] ^ lfsr[4]};
         end
      end
   end

   // Low byte after the advance stands in for the filter output
   assign o_sample.valid = valid;
   assign o_sample.data  = lfsr[log_pkg::NB_DATA_LOG-1:0];

endmodule

`default_nettype wire

//--- hdl/capture_fsm.sv
// Run/idle FSM driving the capture write counter
`default_nettype none
`timescale 1ns/100ps

module capture_fsm (
   input  wire logic i_clock,
   input  wire logic i_counter_rst,
   input  wire logic i_run,            // Run and not yet full
   input  wire logic i_run_complete,   // Last address being written
   output logic      o_rst_cnt,
   output logic      o_en_cnt
);

   typedef enum logic {
      ST_IDLE,
      ST_CAPTURE
   } state_t;

   state_t state;
   state_t next_state;

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////
   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE: begin
            if (i_run) begin
               next_state = ST_CAPTURE;
            end
         end
         ST_CAPTURE: begin
            // Stop on run low or once the log is filled
            if (!i_run || i_run_complete) begin
               next_state = ST_IDLE;
            end
         end
         default: begin
            next_state = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (i_counter_rst) begin
         state <= ST_IDLE;
      end else begin
         state <= next_state;
      end
   end

   // Run dropping clears the counter in the same clock the full flag clears
   assign o_rst_cnt = (state == ST_IDLE) | !i_run;
   assign o_en_cnt  = (state == ST_CAPTURE) & i_run;

endmodule

`default_nettype wire

//--- hdl/capture_bram.sv
// Simple dual port block RAM, synchronous write and registered read
`default_nettype none
`timescale 1ns/100ps

module capture_bram #(
   parameter int NB_DATA = 8,
   parameter int NB_ADDR = 5
) (
   input  wire logic               i_clock,
   input  wire logic               i_write_enable,
   input  wire logic [NB_ADDR-1:0] i_write_addr,
   input  wire logic [NB_DATA-1:0] i_data,
   input  wire logic [NB_ADDR-1:0] i_read_addr,
   output logic [NB_DATA-1:0]      o_data
);

   localparam int DEPTH = 2 ** NB_ADDR;

   logic [NB_DATA-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge i_clock) begin
      if (i_write_enable) begin
         mem[i_write_addr] <= i_data;
      end
   end

   // Read port, always enabled
   always_ff @(posedge i_clock) begin
      o_data <= mem[i_read_addr];
   end

endmodule

`default_nettype wire

//--- hdl/capture_ram.sv
// Capture buffer with write counter, sticky full flag, read registers, FSM and BRAM
`default_nettype none
`timescale 1ns/100ps

module capture_ram #(
   parameter int NB_DATA = 8,
   parameter int NB_ADDR = 5
) (
   input  wire logic                  i_clock,
   input  wire logic                  i_counter_rst,
   input  wire log_pkg::sample_t      i_sample,
   input  wire logic                  i_run,
   input  wire logic [NB_ADDR-1:0]    i_read_addr,
   output logic [NB_DATA-1:0]         o_read_data,
   output log_pkg::log_status_t       o_status
);

   logic               rst_cnt;
   logic               en_cnt;
   logic               write_en;
   logic               counter_full;
   logic               last_write;
   logic               full;
   logic [NB_ADDR-1:0] counter;        // Write address
   logic [NB_ADDR-1:0] read_addr_q;
   logic [NB_DATA-1:0] bram_data;

   assign write_en     = en_cnt & i_sample.valid;   // Drops samples while idle
   assign counter_full = (counter == {NB_ADDR{1'b1}});
   assign last_write   = write_en & counter_full;

   ////////////////////////////////////////////////////////////
   // Read path registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      read_addr_q <= i_read_addr;
      o_read_data <= bram_data;
   end

   ////////////////////////////////////////////////////////////
   // Write counter and full flag
   ////////////////////////////////////////////////////////////
   // Wraps to zero on the last write and parks there until run drops
   always_ff @(posedge i_clock) begin
      if (i_counter_rst || rst_cnt) begin
         counter <= '0;
      end else if (write_en) begin
         counter <= counter + 1'b1;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_counter_rst || !i_run) begin
         full <= 1'b0;
      end else if (last_write) begin
         full <= 1'b1;   // Sticky while run stays high
      end
   end

   // Full bit on top of the parked counter gives 2**NB_ADDR
   assign o_status.full  = full;
   assign o_status.run   = i_run;
   assign o_status.count = {full, counter};

   capture_fsm u_capture_fsm (
      .i_clock        (i_clock        ),
      .i_counter_rst  (i_counter_rst  ),
      .i_run          (i_run & !full  ),
      .i_run_complete (last_write     ),
      .o_rst_cnt      (rst_cnt        ),
      .o_en_cnt       (en_cnt         )
   );

   capture_bram #(
      .NB_DATA (NB_DATA),
      .NB_ADDR (NB_ADDR)
   ) u_capture_bram (
      .i_clock        (i_clock        ),
      .i_write_enable (write_en       ),
      .i_write_addr   (counter        ),
      .i_data         (i_sample.data  ),
      .i_read_addr    (read_addr_q    ),
      .o_data         (bram_data      )
   );

endmodule

`default_nettype wire

//--- hdl/wb_log_reader.sv
// Wishbone classic slave with run control, status decode and ack timing
`default_nettype none
`timescale 1ns/100ps

module wb_log_reader #(
   parameter int NB_DATA = 8,
   parameter int NB_ADDR = 5
) (
   input  wire logic                  i_clock,
   input  wire logic                  i_counter_rst,
   input  wire log_pkg::wb_req_t      i_wb,
   input  wire logic [NB_DATA-1:0]    i_read_data,
   input  wire log_pkg::log_status_t  i_status,
   output log_pkg::wb_rsp_t           o_wb,
   output logic                       o_run,
   output logic [NB_ADDR-1:0]         o_read_addr
);

   localparam logic [1:0] LOG_WAIT = 2'd1;   // Covers address reg and BRAM read

   logic               req;
   logic               status_sel;
   logic               log_read;
   logic               busy;
   logic [1:0]         wait_cnt;
   logic               ack;
   log_pkg::log_word_u read_word;

   assign req         = i_wb.cyc & i_wb.stb;
   assign status_sel  = i_wb.addr[log_pkg::NB_WB_ADDR-1];
   assign log_read    = !i_wb.we && !status_sel;
   assign o_read_addr = i_wb.addr[NB_ADDR-1:0];

   ////////////////////////////////////////////////////////////
   // Ack timing
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_clock) begin
      if (i_counter_rst) begin
         ack      <= 1'b0;
         busy     <= 1'b0;
         wait_cnt <= '0;
      end else if (ack) begin
         ack  <= 1'b0;   // Single clock ack
         busy <= 1'b0;
      end else if (busy) begin
         if (wait_cnt == '0) begin
            ack <= 1'b1;
         end else begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end else if (req) begin
         if (log_read) begin
            busy     <= 1'b1;
            wait_cnt <= LOG_WAIT;
         end else begin
            ack <= 1'b1;   // Status reads and all writes
         end
      end
   end

   // Control register commits in the ack clock
   always_ff @(posedge i_clock) begin
      if (i_counter_rst) begin
         o_run <= 1'b0;
      end else if (ack && req && i_wb.we && status_sel) begin
         o_run <= i_wb.data[0];
      end
   end

   always_comb begin
      read_word = '0;
      if (status_sel) begin
         read_word.status = i_status;
      end else begin
         read_word.sample = i_read_data;
      end
   end

   assign o_wb.ack  = ack & req;   // Never without stb
   assign o_wb.data = read_word;

endmodule

`default_nettype wire

//--- hdl/log_capture_top.sv
// Top level joining the symbol source, capture buffer and Wishbone reader
`default_nettype none
`timescale 1ns/100ps

module log_capture_top #(
   parameter int NB_DATA       = log_pkg::NB_DATA_LOG,
   parameter int NB_ADDR       = log_pkg::NB_ADDR_LOG,
   parameter int SAMPLE_PERIOD = 3
) (
   input  wire logic              i_clock,
   input  wire logic              i_counter_rst,
   input  wire log_pkg::wb_req_t  i_wb,
   output log_pkg::wb_rsp_t       o_wb
);

   ////////////////////////////////////////////////////////////
   // Interconnect
   ////////////////////////////////////////////////////////////
   log_pkg::sample_t     sample;      // Producer to buffer
   logic                 run;
   logic [NB_ADDR-1:0]   read_addr;
   logic [NB_DATA-1:0]   read_data;
   log_pkg::log_status_t status;

   // Producer
   prbs_symbol_source #(
      .SAMPLE_PERIOD (SAMPLE_PERIOD)
   ) u_source (
      .i_clock       (i_clock       ),
      .i_counter_rst (i_counter_rst ),
      .o_sample      (sample        )
   );

   // Buffer
   capture_ram #(
      .NB_DATA (NB_DATA),
      .NB_ADDR (NB_ADDR)
   ) u_capture (
      .i_clock       (i_clock       ),
      .i_counter_rst (i_counter_rst ),
      .i_sample      (sample        ),
      .i_run         (run           ),
      .i_read_addr   (read_addr     ),
      .o_read_data   (read_data     ),
      .o_status      (status        )
   );

   // Consumer
   wb_log_reader #(
      .NB_DATA (NB_DATA),
      .NB_ADDR (NB_ADDR)
   ) u_reader (
      .i_clock       (i_clock       ),
      .i_counter_rst (i_counter_rst ),
      .i_wb          (i_wb          ),
      .i_read_data   (read_data     ),
      .i_status      (status        ),
      .o_wb          (o_wb          ),
      .o_run         (run           ),
      .o_read_addr   (read_addr     )
   );

endmodule

`default_nettype wire

//--- dv/clock_gen.sv
// Free running testbench clock source
`default_nettype none
`timescale 1ns/100ps

module clock_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic o_clock
);

   initial begin
      o_clock = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clock = ~o_clock;   // Half period per toggle
      end
   end

endmodule

`default_nettype wire

//--- dv/tb_log_capture.sv
// Testbench with Wishbone master tasks, PRBS9 reference, sequence compare and watchdog
`default_nettype none
`timescale 1ns/100ps

module tb_log_capture;

   localparam int NB_DATA         = log_pkg::NB_DATA_LOG;
   localparam int NB_ADDR         = log_pkg::NB_ADDR_LOG;
   localparam int NB_WB_ADDR      = log_pkg::NB_WB_ADDR;
   localparam int NB_COUNT        = log_pkg::NB_COUNT;
   localparam int LOG_DEPTH       = 2 ** NB_ADDR;
   localparam int SAMPLE_PERIOD   = 3;
   localparam int PRBS_PERIOD     = 511;
   localparam int RESET_CYCLES    = 4;
   localparam int LOG_LATENCY     = 3;
   localparam int STATUS_LATENCY  = 1;
   localparam int ACK_LIMIT       = 16;    // Clocks before a cycle is abandoned
   localparam int POLL_LIMIT      = 200;
   // Two captures plus about 80 bus cycles of 6 clocks with margin
   localparam int WATCHDOG_CLOCKS = 4 * (2 * LOG_DEPTH * SAMPLE_PERIOD + 80 * 6);

   localparam logic [NB_WB_ADDR-1:0] STATUS_ADDR = 6'h20;

   logic             clock;
   logic             counter_rst;
   log_pkg::wb_req_t wb_req;
   log_pkg::wb_rsp_t wb_rsp;

   integer seed;
   int     error_count        = 0;
   int     ack_errors         = 0;    // From the ack monitor
   int     compare_errors     = 0;    // From the sequence compare
   int     failed_tests       = 0;
   int     compares_requested = 0;
   int     compares_done      = 0;

   logic [NB_DATA-1:0] check_log  [LOG_DEPTH];
   logic [NB_DATA-1:0] first_log  [LOG_DEPTH];
   logic [NB_DATA-1:0] second_log [LOG_DEPTH];

   clock_gen #(
      .PERIOD_NS (4)
   ) u_clock_gen (
      .o_clock (clock)
   );

   log_capture_top u_dut (
      .i_clock       (clock       ),
      .i_counter_rst (counter_rst ),
      .i_wb          (wb_req      ),
      .o_wb          (wb_rsp      )
   );

   ////////////////////////////////////////////////////////////
   // Reference model and helpers
   ////////////////////////////////////////////////////////////
   // PRBS9 step with taps 9 and 5 shifting left
   function automatic logic [8:0] prbs_next(input logic [8:0] state);
      return {state[7:0], state[8] ^ state[4]};
   endfunction

   function automatic log_pkg::log_status_t status_word(input logic full, input logic run,
                                                        input logic [NB_COUNT-1:0] count);
      log_pkg::log_status_t word;
      word.full  = full;
      word.run   = run;
      word.count = count;
      return word;
   endfunction

   function automatic int total_errors();
      return error_count + ack_errors + compare_errors;
   endfunction

   task automatic report_mismatch(input string name, input int expected, input int actual);
      $display("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
   endtask

   task automatic idle_gap();
      int gap;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clock);
   endtask

   ////////////////////////////////////////////////////////////
   // Wishbone master
   ////////////////////////////////////////////////////////////
   // Holds the request until ack is seen and drops it one clock later
   task automatic await_ack(output logic [NB_DATA-1:0] rdata, output int latency);
      bit acked;
      acked   = 1'b0;
      latency = 0;
      rdata   = '0;
      while (!acked && latency < ACK_LIMIT) begin
         @(posedge clock);
         latency++;
         @(negedge clock);   // Mid cycle where ack and data are settled
         if (wb_rsp.ack) begin
            acked = 1'b1;
            rdata = wb_rsp.data;
         end
      end
      if (!acked) begin
         $display("Bus error at %0d ns: no ack within %0d clocks for address 0x%0h",
                  $time, ACK_LIMIT, wb_req.addr);
         error_count++;
      end
      @(posedge clock);
      #1;
      wb_req = '0;
   endtask

   task automatic read_cycle(input logic [NB_WB_ADDR-1:0] addr,
                             output logic [NB_DATA-1:0] rdata);
      int latency;
      int expected_latency;
      @(posedge clock);
      #1;
      wb_req.cyc  = 1'b1;
      wb_req.stb  = 1'b1;
      wb_req.we   = 1'b0;
      wb_req.addr = addr;
      wb_req.data = '0;
      await_ack(rdata, latency);
      expected_latency = addr[NB_WB_ADDR-1] ? STATUS_LATENCY : LOG_LATENCY;
      if (latency != expected_latency) begin
         report_mismatch($sformatf("o_wb.ack latency, address 0x%0h", addr),
                         expected_latency, latency);
         error_count++;
      end
   endtask

   task automatic write_cycle(input logic [NB_WB_ADDR-1:0] addr,
                              input logic [NB_DATA-1:0] wdata);
      logic [NB_DATA-1:0] unused_data;
      int                 latency;
      @(posedge clock);
      #1;
      wb_req.cyc  = 1'b1;
      wb_req.stb  = 1'b1;
      wb_req.we   = 1'b1;
      wb_req.addr = addr;
      wb_req.data = wdata;
      await_ack(unused_data, latency);
      if (latency != STATUS_LATENCY) begin   // All writes ack in one clock
         report_mismatch("o_wb.ack write latency", STATUS_LATENCY, latency);
         error_count++;
      end
   endtask

   task automatic check_status(input log_pkg::log_status_t expected, input string name);
      logic [NB_DATA-1:0] rdata;
      read_cycle(STATUS_ADDR, rdata);
      if (rdata != expected) begin
         report_mismatch(name, int'(expected), int'(rdata));
         error_count++;
      end
   endtask

   task automatic poll_until_full();
      logic [NB_DATA-1:0]   rdata;
      log_pkg::log_status_t status;
      bit                   filled;
      filled = 1'b0;
      for (int poll = 0; poll < POLL_LIMIT && !filled; poll++) begin
         idle_gap();
         read_cycle(STATUS_ADDR, rdata);
         status = rdata;
         filled = status.full;
      end
      if (!filled) begin
         $display("Timeout at %0d ns: log not full after %0d status polls", $time, POLL_LIMIT);
         error_count++;
      end
   endtask

   task automatic read_log();
      logic [NB_DATA-1:0] rdata;
      for (int a = 0; a < LOG_DEPTH; a++) begin
         idle_gap();
         read_cycle(NB_WB_ADDR'(a), rdata);
         check_log[a] = rdata;
      end
   endtask

   // Hands check_log to the compare process and waits for its verdict
   task automatic compare_log();
      compares_requested++;
      wait (compares_done == compares_requested);
   endtask

   task automatic finish_test(input int number, input string name, input int errors_before);
      int errors_now;
      errors_now = total_errors();
      if (errors_now != errors_before) begin
         failed_tests++;
      end
      $display("Test %0d %s: %0d errors", number, name, errors_now - errors_before);
   endtask

   ////////////////////////////////////////////////////////////
   // Checkers
   ////////////////////////////////////////////////////////////
   always @(negedge clock) begin
      if (wb_rsp.ack && !(wb_req.cyc && wb_req.stb)) begin
         report_mismatch("o_wb.ack with stb low", 0, 1);
         ack_errors++;
      end
   end

   // Finds entry 0 in the model sequence and requires the rest to follow it
   initial begin : compare_process
      logic [8:0]         state;
      logic [8:0]         probe;
      logic [NB_DATA-1:0] bad_expected;
      int                 start;
      int                 candidate;
      int                 bad_index;
      bit                 matched;
      forever begin
         wait (compares_requested > compares_done);
         start        = -1;
         candidate    = -1;
         bad_index    = 0;
         bad_expected = '0;
         state        = log_pkg::PRBS_SEED;
         for (int k = 1; k <= PRBS_PERIOD && start < 0; k++) begin
            state = prbs_next(state);
            if (state[NB_DATA-1:0] == check_log[0]) begin
               if (candidate < 0) begin
                  candidate = k;
               end
               probe   = state;
               matched = 1'b1;
               for (int i = 1; i < LOG_DEPTH; i++) begin
                  probe = prbs_next(probe);
                  if (matched && probe[NB_DATA-1:0] != check_log[i]) begin
                     matched = 1'b0;
                     if (candidate == k) begin   // Keep the first mismatch
                        bad_index    = i;
                        bad_expected = probe[NB_DATA-1:0];
                     end
                  end
               end
               if (matched) begin
                  start = k;
               end
            end
         end
         if (start < 0 && candidate < 0) begin
            $display("Sequence error at %0d ns: log entry 0 (0x%0h) is not a PRBS9 value",
                     $time, check_log[0]);
            compare_errors++;
         end else if (start < 0) begin
            report_mismatch($sformatf("log entry %0d", bad_index), int'(bad_expected),
                            int'(check_log[bad_index]));
            compare_errors++;
         end
         compares_done++;
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CLOCKS) @(posedge clock);
      $display("Watchdog expired after %0d clocks, the tests did not complete",
               WATCHDOG_CLOCKS);
      $display("test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin : main
      logic [NB_DATA-1:0] rdata;
      int                 errors_before;
      int                 wr_addr;
      int                 order [LOG_DEPTH];
      int                 pick;
      int                 swap;

      seed        = 32'h2d76;
      counter_rst = 1'b1;
      wb_req      = '0;
      repeat (RESET_CYCLES) @(posedge clock);
      #1;
      counter_rst = 1'b0;

      errors_before = total_errors();
      check_status(status_word(1'b0, 1'b0, '0), "o_wb.data status after reset");
      finish_test(1, "reset status", errors_before);

      errors_before = total_errors();
      write_cycle(STATUS_ADDR, 8'h01);   // Run
      poll_until_full();
      check_status(status_word(1'b1, 1'b1, NB_COUNT'(LOG_DEPTH)), "o_wb.data status full");
      repeat (3) begin
         idle_gap();
         check_status(status_word(1'b1, 1'b1, NB_COUNT'(LOG_DEPTH)), "o_wb.data status held");
      end
      finish_test(2, "capture fills log", errors_before);

      errors_before = total_errors();
      read_log();
      compare_log();
      first_log = check_log;
      finish_test(3, "contiguous PRBS log", errors_before);

      errors_before = total_errors();
      write_cycle(STATUS_ADDR, 8'h00);   // Stop clears count and full
      idle_gap();
      check_status(status_word(1'b0, 1'b0, '0), "o_wb.data status after stop");
      write_cycle(STATUS_ADDR, 8'h01);
      poll_until_full();
      read_log();
      compare_log();
      second_log = check_log;
      if (second_log[0] == first_log[0]) begin
         $display("Capture error at %0d ns: second log starts with the same entry 0x%0h",
                  $time, second_log[0]);
         error_count++;
      end
      finish_test(4, "second capture", errors_before);

      errors_before = total_errors();
      wr_addr = $unsigned($random(seed)) % LOG_DEPTH;
      write_cycle(NB_WB_ADDR'(wr_addr), ~second_log[wr_addr]);   // Must be ignored
      for (int i = 0; i < LOG_DEPTH; i++) begin
         order[i] = i;
      end
      for (int i = LOG_DEPTH - 1; i > 0; i--) begin
         pick        = $unsigned($random(seed)) % (i + 1);
         swap        = order[i];
         order[i]    = order[pick];
         order[pick] = swap;
      end
      for (int i = 0; i < LOG_DEPTH; i++) begin
         idle_gap();
         read_cycle(NB_WB_ADDR'(order[i]), rdata);
         if (rdata != second_log[order[i]]) begin
            report_mismatch($sformatf("o_wb.data log[%0d]", order[i]),
                            int'(second_log[order[i]]), int'(rdata));
            error_count++;
         end
         if (i % 8 == 7) begin
            idle_gap();
            check_status(status_word(1'b1, 1'b1, NB_COUNT'(LOG_DEPTH)),
                         "o_wb.data status in readout");
         end
      end
      finish_test(5, "log write ignored and ack timing", errors_before);

      $display("Tests run 5, tests with errors %0d, total errors %0d",
               failed_tests, total_errors());
      if (total_errors() == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
hdl/log_pkg.sv
hdl/prbs_symbol_source.sv
hdl/capture_fsm.sv
hdl/capture_bram.sv
hdl/capture_ram.sv
hdl/wb_log_reader.sv
hdl/log_capture_top.sv
dv/clock_gen.sv
dv/tb_log_capture.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_log_capture -f sim.f \
   && ./obj_dir/Vtb_log_capture > sim.log 2>&1 \
   || { echo "Build or simulation error"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log \
   && echo "Simulation PASS" \
   || { echo "Simulation FAIL"; exit 1; }
